// File: Makefile
# Verilator build and run of the PI-bus slave subsystem testbench
VERILATOR ?= verilator
TOP       ?= pi_bus_tb
FLIST     ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
PASS_MSG  ?= *** PASSED ***

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

// File: rtl/pi_addr_decoder.sv
// address decoder: fans the master request out to the addressed slave, times out stalled requests
`timescale 1ns/1ps
`include "pi_bus_params.svh"

module pi_addr_decoder (
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 sel,
   input  logic                 read,
   input  pi_bus_pkg::pi_addr_t addr,
   input  pi_bus_pkg::pi_data_t wdata,
   input  pi_bus_pkg::pi_ack_t  ack,      // registered bus ack from the collector
   output logic                 timeout,  // one cycle pulse to the master
   pi_slave_if.decoder          slv [0:`PI_NUM_SLAVES-1]
);
   import pi_bus_pkg::*;

   pi_slv_t  idx;       // slave index, top address bits
   pi_offs_t offs;      // offset, remaining bits
   pi_cnt_t  cnt;       // held select cycles so far
   logic     done;      // RDY or ERR seen for this request
   pi_slv_t  tout_idx;  // slave that owns the pulse
   logic     ack_end;   // request finished on the bus

   assign idx  = addr[0:`PI_SEL_BITS-1];
   assign offs = addr[`PI_SEL_BITS:`PI_ADDR_W-1];

   // bus ack trails sel by two cycles, so the first held cycle can still show the last answer
   assign ack_end = (cnt != '0) && (ack == RDY || ack == ERR);

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         cnt     <= '0;
         done    <= 1'b0;
         timeout <= 1'b0;
      end
      else
      begin
         timeout <= 1'b0;                                  // pulse only
         if (!sel)
         begin
            cnt  <= '0;                                    // idle bus, rearm
            done <= 1'b0;
         end
         else if (!done)
         begin
            if (ack_end)
               done <= 1'b1;                               // stop counting
            else if (cnt == pi_cnt_t'(`PI_TOUT_CYCLES - 1))
            begin
               cnt      <= '0;                             // restart after the pulse
               timeout  <= 1'b1;
               tout_idx <= idx;
            end
            else
               cnt <= cnt + 1'b1;
         end
      end
   end

   // select goes to one slave only, the rest is broadcast
   for (genvar i = 0; i < `PI_NUM_SLAVES; i++)
   begin : g_fan
      assign slv[i].sel   = sel && (idx == pi_slv_t'(i));
      assign slv[i].read  = read;
      assign slv[i].offs  = offs;
      assign slv[i].wdata = wdata;
      assign slv[i].tout  = timeout && (tout_idx == pi_slv_t'(i));
   end

endmodule

// File: rtl/pi_bus_params.svh
// width, address map and timing macros shared by the rtl and the testbench; include where needed
`ifndef PI_BUS_PARAMS_SVH
`define PI_BUS_PARAMS_SVH

`define PI_DATA_W      32                           // data word
`define PI_ADDR_W      30                           // word address
`define PI_NUM_SLAVES  4                            // slave units on the bus
`define PI_SEL_BITS    2                            // top address bits 0:1 pick the slave
`define PI_OFFS_W      (`PI_ADDR_W - `PI_SEL_BITS)  // offset inside one slave window
`define PI_STORE_DEPTH 16                           // words per store
`define PI_IDX_W       4                            // store index bits, log2 of depth
`define PI_RD_LAT      3                            // normal region read latency
`define PI_SLOW_BASE   12                           // first offset of the slow region
`define PI_SLOW_LAT    12                           // slow region read latency
`define PI_WR_BUSY     2                            // drain cycles after a posted write
`define PI_TOUT_CYCLES 8                            // held select cycles before timeout
`define PI_CNT_W       4                            // latency, drain and timeout counters

`endif

// File: rtl/pi_bus_pkg.sv
// shared PI-bus types; import into module bodies, use scoped names in port lists
`include "pi_bus_params.svh"

package pi_bus_pkg;

   // acknowledge code, per slave and on the bus
   typedef enum logic [1:0] {
      IDLE = 2'd0,  // no answer, also the value of an unselected slave
      RDY  = 2'd1,  // access done, rdata valid on reads
      WAT  = 2'd2,  // master keeps holding
      ERR  = 2'd3   // offset outside the store
   } pi_ack_t;

   // data word, bit 0 is the msb
   typedef logic [0:`PI_DATA_W-1] pi_data_t;

   // full word address, slave index in the top bits
   typedef logic [0:`PI_ADDR_W-1] pi_addr_t;

   // offset below the select bits
   typedef logic [0:`PI_OFFS_W-1] pi_offs_t;

   // slave index
   typedef logic [0:`PI_SEL_BITS-1] pi_slv_t;

   // word index inside one store
   typedef logic [0:`PI_IDX_W-1] pi_idx_t;

   // cycle counters
   typedef logic [0:`PI_CNT_W-1] pi_cnt_t;

endpackage

// File: rtl/pi_bus_top.sv
// PI-bus slave subsystem top: decoder, four slave units and the response collector on plain ports
`timescale 1ns/1ps
`include "pi_bus_params.svh"

module pi_bus_top (
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 sel,        // master request, held until the end
   input  logic                 read,
   input  pi_bus_pkg::pi_addr_t addr,
   input  pi_bus_pkg::pi_data_t wdata,
   output pi_bus_pkg::pi_ack_t  ack,        // two cycles behind the request
   output pi_bus_pkg::pi_data_t rdata,
   output logic                 timeout,
   output logic                 bus_fault
);
   import pi_bus_pkg::*;

   pi_slave_if slv_if [0:`PI_NUM_SLAVES-1] ();  // one bundle per slave

   pi_addr_decoder u_dec (
      .clk     (clk),
      .rst     (rst),
      .sel     (sel),
      .read    (read),
      .addr    (addr),
      .wdata   (wdata),
      .ack     (ack),                             // ends the timeout count
      .timeout (timeout),
      .slv     (slv_if)
   );

   for (genvar i = 0; i < `PI_NUM_SLAVES; i++)
   begin : g_unit
      logic     access;
      logic     acc_read;
      pi_offs_t acc_offs;
      pi_data_t acc_wdata;
      pi_data_t acc_rdata;
      logic     data_ready;
      logic     filled;
      logic     error;

      pi_slave_fsm u_fsm (
         .clk        (clk),
         .rst        (rst),
         .bus        (slv_if[i]),
         .access     (access),
         .acc_read   (acc_read),
         .acc_offs   (acc_offs),
         .acc_wdata  (acc_wdata),
         .data_ready (data_ready),
         .filled     (filled),
         .error      (error),
         .acc_rdata  (acc_rdata)
      );

      pi_slave_store u_store (
         .clk        (clk),
         .rst        (rst),
         .access     (access),
         .read       (acc_read),
         .offs       (acc_offs),
         .wdata      (acc_wdata),
         .data_ready (data_ready),
         .filled     (filled),
         .error      (error),
         .rdata      (acc_rdata)
      );
   end

   pi_resp_collector u_col (
      .clk       (clk),
      .rst       (rst),
      .slv       (slv_if),
      .ack       (ack),
      .rdata     (rdata),
      .bus_fault (bus_fault)
   );

endmodule

// File: rtl/pi_resp_collector.sv
// response collector: merges the slave answers into the registered bus ack and read data
`timescale 1ns/1ps
`include "pi_bus_params.svh"

module pi_resp_collector (
   input  logic                 clk,
   input  logic                 rst,
   pi_slave_if.collector        slv [0:`PI_NUM_SLAVES-1],
   output pi_bus_pkg::pi_ack_t  ack,
   output pi_bus_pkg::pi_data_t rdata,
   output logic                 bus_fault  // sticky, two answers at once
);
   import pi_bus_pkg::*;

   pi_ack_t    ack_v   [0:`PI_NUM_SLAVES-1];
   pi_data_t   rdata_v [0:`PI_NUM_SLAVES-1];
   logic [0:1] ack_m;    // OR of all answers
   pi_data_t   rdata_m;
   logic       multi;    // more than one slave not IDLE

   // a slave being timed out still shows WAT for one cycle, hide it
   for (genvar i = 0; i < `PI_NUM_SLAVES; i++)
   begin : g_tap
      assign ack_v[i]   = slv[i].tout ? IDLE : slv[i].ack;
      assign rdata_v[i] = slv[i].rdata;
   end

   // idle slaves give IDLE and 0, so a plain OR merges
   always_comb
   begin
      logic seen;
      seen    = 1'b0;
      ack_m   = '0;
      rdata_m = '0;
      multi   = 1'b0;
      for (int i = 0; i < `PI_NUM_SLAVES; i++)
      begin
         ack_m   = ack_m | ack_v[i];
         rdata_m = rdata_m | rdata_v[i];
         if (ack_v[i] != IDLE)
         begin
            multi = multi | seen;
            seen  = 1'b1;
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         ack       <= IDLE;
         rdata     <= '0;
         bus_fault <= 1'b0;
      end
      else
      begin
         ack   <= pi_ack_t'(ack_m);
         rdata <= rdata_m;
         if (multi)
            bus_fault <= 1'b1;                          // held until reset
      end
   end

endmodule

// File: rtl/pi_slave_fsm.sv
// slave protocol FSM: answers one bus request with RDY, WAT or ERR from the state of its store
`timescale 1ns/1ps

module pi_slave_fsm (
   input  logic                 clk,
   input  logic                 rst,
   pi_slave_if.slave            bus,
   output logic                 access,      // request outstanding at the store
   output logic                 acc_read,
   output pi_bus_pkg::pi_offs_t acc_offs,
   output pi_bus_pkg::pi_data_t acc_wdata,
   input  logic                 data_ready,  // read data valid
   input  logic                 filled,      // write path busy
   input  logic                 error,       // bad offset
   input  pi_bus_pkg::pi_data_t acc_rdata
);
   import pi_bus_pkg::*;

   typedef enum logic [1:0] {
      S_RESET     = 2'd0,
      S_ADDRESS   = 2'd1,
      S_DATA_WAIT = 2'd2
   } state_t;

   state_t   state;
   logic     served;   // answered, wait for sel to drop
   logic     rd_q;     // latched request
   pi_offs_t offs_q;
   pi_data_t wdata_q;
   logic     new_req;  // fresh request in address state
   logic     waiting;
   logic     done_ok;  // store can finish this cycle

   assign new_req = (state == S_ADDRESS) && bus.sel && !served;
   assign waiting = (state == S_DATA_WAIT);

   // first cycle comes straight from the bus, later cycles from the latch
   assign access    = new_req || (waiting && bus.sel);  // dropped sel ends the access
   assign acc_read  = waiting ? rd_q : bus.read;
   assign acc_offs  = waiting ? offs_q : bus.offs;
   assign acc_wdata = waiting ? wdata_q : bus.wdata;

   // same condition the store uses to take a write
   assign done_ok = acc_read ? data_ready : !filled;

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         state     <= S_RESET;
         served    <= 1'b0;
         bus.ack   <= IDLE;
         bus.rdata <= '0;
      end
      else
      begin
         case (state)
            S_RESET:
            begin
               state     <= S_ADDRESS;
               bus.ack   <= IDLE;
               bus.rdata <= '0;
            end
            S_ADDRESS:
            begin
               if (!bus.sel)
               begin
                  served    <= 1'b0;                      // ready for the next request
                  bus.ack   <= IDLE;
                  bus.rdata <= '0;
               end
               else if (!served)
               begin
                  rd_q    <= bus.read;
                  offs_q  <= bus.offs;
                  wdata_q <= bus.wdata;
                  if (error)
                  begin
                     bus.ack   <= ERR;
                     bus.rdata <= '0;
                     served    <= 1'b1;
                  end
                  else if (done_ok)
                  begin
                     bus.ack   <= RDY;
                     bus.rdata <= bus.read ? acc_rdata : '0;
                     served    <= 1'b1;
                  end
                  else
                  begin
                     bus.ack <= WAT;                       // store holds us off
                     state   <= S_DATA_WAIT;
                  end
               end
            end
            S_DATA_WAIT:
            begin
               if (!bus.sel)
               begin
                  state     <= S_ADDRESS;                 // master gave up
                  bus.ack   <= IDLE;
                  bus.rdata <= '0;
               end
               else if (error)
               begin
                  state     <= S_ADDRESS;
                  bus.ack   <= ERR;
                  bus.rdata <= '0;
                  served    <= 1'b1;
               end
               else if (done_ok)
               begin
                  state     <= S_ADDRESS;
                  bus.ack   <= RDY;
                  bus.rdata <= rd_q ? acc_rdata : '0;
                  served    <= 1'b1;
               end
               else if (bus.tout)
               begin
                  state     <= S_ADDRESS;                 // abort, no answer
                  bus.ack   <= IDLE;
                  bus.rdata <= '0;
                  served    <= 1'b1;
               end
            end
            default:
               state <= S_RESET;
         endcase
      end
   end

endmodule

// File: rtl/pi_slave_if.sv
// request/response bundle of one slave unit, shared by decoder, slave FSM and collector
`timescale 1ns/1ps

interface pi_slave_if;
   import pi_bus_pkg::*;

   // request side, from the decoder
   logic     sel;    // request addressed to this slave
   logic     read;   // 1 read, 0 write
   pi_offs_t offs;   // word offset in the window
   pi_data_t wdata;  // write data
   logic     tout;   // bus timeout for this slave, one cycle

   // response side, from the slave FSM
   pi_ack_t  ack;    // IDLE when not selected
   pi_data_t rdata;  // 0 unless RDY on a read

   modport decoder (
      output sel, read, offs, wdata, tout
   );

   modport slave (
      input  sel, read, offs, wdata, tout,
      output ack, rdata
   );

   // tout lets the collector drop a stale WAT of an aborted request
   modport collector (
      input ack, rdata, tout
   );

endinterface

// File: rtl/pi_slave_store.sv
// word store behind one slave FSM: read latency, posted write with drain, range error
`timescale 1ns/1ps
`include "pi_bus_params.svh"

module pi_slave_store (
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 access,
   input  logic                 read,
   input  pi_bus_pkg::pi_offs_t offs,
   input  pi_bus_pkg::pi_data_t wdata,
   output logic                 data_ready,
   output logic                 filled,
   output logic                 error,
   output pi_bus_pkg::pi_data_t rdata
);
   import pi_bus_pkg::*;

   pi_data_t mem [0:`PI_STORE_DEPTH-1];
   pi_idx_t  idx;        // low offset bits
   logic     in_range;   // upper offset bits all zero
   logic     slow;       // slow region, top words
   pi_cnt_t  lat_cnt;    // cycles into the current read
   pi_cnt_t  lat_tgt;
   logic     post_vld;   // accepted write, not yet in mem
   pi_idx_t  post_idx;
   pi_data_t post_data;
   pi_cnt_t  drain_cnt;  // remaining drain cycles
   logic     wr_go;      // write taken this cycle

   assign idx      = offs[`PI_OFFS_W-`PI_IDX_W:`PI_OFFS_W-1];
   assign in_range = (offs[0:`PI_OFFS_W-`PI_IDX_W-1] == '0);
   assign slow     = (idx >= pi_idx_t'(`PI_SLOW_BASE));
   assign lat_tgt  = slow ? pi_cnt_t'(`PI_SLOW_LAT) : pi_cnt_t'(`PI_RD_LAT);

   assign error      = access && !in_range;                      // first access cycle already
   assign data_ready = access && read && in_range && (lat_cnt == lat_tgt);
   assign filled     = post_vld || (drain_cnt != '0);           // posting cycle plus drain
   assign rdata      = in_range ? mem[idx] : '0;
   assign wr_go      = access && !read && in_range && !filled;  // FSM answers RDY here

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         lat_cnt   <= '0;
         post_vld  <= 1'b0;
         drain_cnt <= '0;
         for (int i = 0; i < `PI_STORE_DEPTH; i++)
            mem[i] <= '0;
      end
      else
      begin
         // latency counter saturates at the target, clears between accesses
         if (!access || !read || !in_range)
            lat_cnt <= '0;
         else if (lat_cnt != lat_tgt)
            lat_cnt <= lat_cnt + 1'b1;

         post_vld <= wr_go;
         if (wr_go)
         begin
            post_idx  <= idx;
            post_data <= wdata;
         end

         if (post_vld)
         begin
            mem[post_idx] <= post_data;                 // write lands one cycle late
            drain_cnt     <= pi_cnt_t'(`PI_WR_BUSY);
         end
         else if (drain_cnt != '0)
            drain_cnt <= drain_cnt - 1'b1;
      end
   end

endmodule

// File: sim/pi_bus_sva.sv
// protocol assertions on the PI-bus top-level ports, bound into the subsystem top below
`timescale 1ns/1ps

module pi_bus_sva (
   input logic                 clk,
   input logic                 rst,
   input logic                 sel,
   input pi_bus_pkg::pi_ack_t  ack,
   input pi_bus_pkg::pi_data_t rdata,
   input logic                 timeout,
   input logic                 bus_fault
);
   import pi_bus_pkg::*;

   // ack runs two registers behind sel, one cycle of slack after sel drops
   a_no_wat_idle: assert property (@(posedge clk) disable iff (rst)
      (!sel && !$past(sel)) |-> (ack != WAT))
      else $error("ack WAT on a deselected bus");

   a_no_fault: assert property (@(posedge clk) disable iff (rst) !bus_fault)
      else $error("bus_fault set, two slaves answered at once");

   a_tout_pulse: assert property (@(posedge clk) disable iff (rst) timeout |=> !timeout)
      else $error("timeout held longer than one cycle");

   a_rst_idle: assert property (@(posedge clk) rst |=> (ack == IDLE && rdata == '0 && !timeout))
      else $error("bus outputs not idle after reset");

endmodule

bind pi_bus_top pi_bus_sva u_sva (
   .clk       (clk),
   .rst       (rst),
   .sel       (sel),
   .ack       (ack),
   .rdata     (rdata),
   .timeout   (timeout),
   .bus_fault (bus_fault)
);

// File: sim/pi_bus_tb.sv
// testbench for the PI-bus slave subsystem; runs a transaction table and random pairs, self-checking
`timescale 1ns/1ps
`include "pi_bus_params.svh"

module pi_bus_tb;
   import pi_bus_pkg::*;

   localparam int n_rand  = 8;   // random write/read pairs
   localparam int rst_cyc = 10;

   logic     clk;
   logic     rst;
   logic     sel;
   logic     read;
   pi_addr_t addr;
   pi_data_t wdata;
   pi_ack_t  ack;
   pi_data_t rdata;
   logic     timeout;
   logic     bus_fault;

   string    t_name  [$];  // transaction table, one queue per column
   logic     t_rd    [$];
   pi_addr_t t_addr  [$];
   pi_data_t t_wdata [$];
   pi_ack_t  t_ack   [$];  // final answer, IDLE means bus timeout
   pi_ack_t  t_first [$];  // first non-IDLE answer seen

   pi_data_t ref_mem [0:`PI_NUM_SLAVES-1][0:`PI_STORE_DEPTH-1];  // expected store contents
   int       errors;
   int       n_pass;
   int       n_fail;
   int       cycles;
   int       cycle_limit;

   pi_bus_top dut_i (
      .clk       (clk),
      .rst       (rst),
      .sel       (sel),
      .read      (read),
      .addr      (addr),
      .wdata     (wdata),
      .ack       (ack),
      .rdata     (rdata),
      .timeout   (timeout),
      .bus_fault (bus_fault)
   );

   initial
   begin
      clk = 1'b0;
      forever
         #20 clk = ~clk;  // 40 ns period
   end

   function automatic pi_addr_t make_addr(input int s, input int o);
      return {pi_slv_t'(s), pi_offs_t'(o)};  // slave index on top
   endfunction

   task automatic add_row(input string name, input logic rd, input int s, input int o,
                          input pi_data_t wd, input pi_ack_t exp, input pi_ack_t first);
      t_name.push_back(name);
      t_rd.push_back(rd);
      t_addr.push_back(make_addr(s, o));
      t_wdata.push_back(wd);
      t_ack.push_back(exp);
      t_first.push_back(first);
   endtask

   task automatic build_table();
      add_row("wr_s0", 1'b0, 0, 1, 32'h0123_4567, RDY, RDY);  // one word per slave
      add_row("rd_s0", 1'b1, 0, 1, '0, RDY, WAT);
      add_row("wr_s1", 1'b0, 1, 0, 32'h89ab_cdef, RDY, RDY);
      add_row("rd_s1", 1'b1, 1, 0, '0, RDY, WAT);
      add_row("wr_s2", 1'b0, 2, 3, 32'hdead_beef, RDY, RDY);
      add_row("rd_s2", 1'b1, 2, 3, '0, RDY, WAT);
      add_row("wr_s3", 1'b0, 3, 2, 32'h5a5a_a5a5, RDY, RDY);
      add_row("rd_s3", 1'b1, 3, 2, '0, RDY, WAT);
      add_row("b2b_wr_a", 1'b0, 2, 5, 32'h1111_1111, RDY, RDY);
      add_row("b2b_wr_b", 1'b0, 2, 5, 32'h2222_2222, RDY, WAT);  // drain still busy
      add_row("b2b_rd", 1'b1, 2, 5, '0, RDY, WAT);
      add_row("oor_wr", 1'b0, 1, 16, 32'hffff_ffff, ERR, ERR);  // aliases offset 0
      add_row("oor_rd", 1'b1, 1, 20, '0, ERR, ERR);
      add_row("oor_chk", 1'b1, 1, 0, '0, RDY, WAT);
      add_row("slow_wr", 1'b0, 3, 13, 32'h3333_3333, RDY, RDY);
      add_row("slow_rd", 1'b1, 3, 13, '0, IDLE, WAT);
      add_row("slow_after", 1'b1, 3, 2, '0, RDY, WAT);
      add_row("ind_wr0", 1'b0, 0, 6, 32'ha000_0000, RDY, RDY);  // same offset everywhere
      add_row("ind_wr1", 1'b0, 1, 6, 32'hb000_0001, RDY, RDY);
      add_row("ind_wr2", 1'b0, 2, 6, 32'hc000_0002, RDY, RDY);
      add_row("ind_wr3", 1'b0, 3, 6, 32'hd000_0003, RDY, RDY);
      add_row("ind_rd0", 1'b1, 0, 6, '0, RDY, WAT);
      add_row("ind_rd1", 1'b1, 1, 6, '0, RDY, WAT);
      add_row("ind_rd2", 1'b1, 2, 6, '0, RDY, WAT);
      add_row("ind_rd3", 1'b1, 3, 6, '0, RDY, WAT);
   endtask

   task automatic check_ack(input string name, input pi_ack_t exp, input pi_ack_t got);
      if (got !== exp)
      begin
         $display("FAIL %s: expected %s, got %s", name, exp.name(), got.name());
         errors++;
      end
   endtask

   task automatic check_data(input string name, input pi_data_t exp, input pi_data_t got);
      if (got !== exp)
      begin
         $display("FAIL %s rdata: expected %h, got %h", name, exp, got);
         errors++;
      end
   endtask

   task automatic check_flag(input string name, input logic exp, input logic got);
      if (got !== exp)
      begin
         $display("FAIL %s: expected %0b, got %0b", name, exp, got);
         errors++;
      end
   endtask

   // one bus request, entered 2 ns after an edge and left the same way
   task automatic run_trans(input string name, input logic rd, input pi_addr_t a,
                            input pi_data_t wd, input pi_ack_t exp_ack,
                            input pi_ack_t exp_first);
      pi_slv_t  si;
      pi_idx_t  oi;
      int       err_before;
      logic     ended;
      pi_ack_t  got_ack;
      pi_ack_t  first;
      pi_data_t got_data;
      pi_data_t exp_data;
      si         = a[0:`PI_SEL_BITS-1];
      oi         = a[`PI_ADDR_W-`PI_IDX_W:`PI_ADDR_W-1];
      err_before = errors;
      exp_data   = (rd && exp_ack == RDY) ? ref_mem[si][oi] : '0;  // reads from the model
      ended      = 1'b0;
      first      = IDLE;
      got_ack    = IDLE;
      got_data   = '0;
      sel        = 1'b1;
      read       = rd;
      addr       = a;
      wdata      = wd;
      while (!ended)
      begin
         @(posedge clk);
         #1;                           // outputs settled
         got_data = rdata;
         if (first == IDLE)
            first = ack;
         if (timeout)
            ended = 1'b1;              // aborted, got_ack stays IDLE
         else if (ack == RDY || ack == ERR)
         begin
            got_ack = ack;
            ended   = 1'b1;
         end
      end
      #1;
      sel   = 1'b0;
      read  = 1'b0;
      addr  = '0;
      wdata = '0;
      check_ack({name, " ack"}, exp_ack, got_ack);
      check_ack({name, " first ack"}, exp_first, first);
      check_data(name, exp_data, got_data);
      check_flag({name, " bus_fault"}, 1'b0, bus_fault);
      if (!rd && exp_ack == RDY)
         ref_mem[si][oi] = wd;         // accepted write
      if (errors == err_before)
      begin
         n_pass++;
         $display("test %s ok", name);
      end
      else
      begin
         n_fail++;
         $display("test %s failed", name);
      end
      @(posedge clk);                  // sel low for one cycle
      #2;
   endtask

   initial
   begin
      pi_addr_t a;
      pi_data_t d;
      void'($urandom(78776));         // single seed
      rst     = 1'b1;
      sel     = 1'b0;
      read    = 1'b0;
      addr    = '0;
      wdata   = '0;
      errors  = 0;
      n_pass  = 0;
      n_fail  = 0;
      ref_mem = '{default: '0};       // stores clear on reset
      build_table();
      cycle_limit = (t_name.size() + 2 * n_rand) * (`PI_SLOW_LAT + 4) + rst_cyc + 4;
      repeat (rst_cyc) @(posedge clk);
      #2;
      rst = 1'b0;
      @(posedge clk);                 // FSMs leave reset state
      #2;
      for (int i = 0; i < t_name.size(); i++)
         run_trans(t_name[i], t_rd[i], t_addr[i], t_wdata[i], t_ack[i], t_first[i]);
      for (int i = 0; i < n_rand; i++)
      begin
         a = make_addr(int'($urandom_range(0, `PI_NUM_SLAVES - 1)),
                       int'($urandom_range(0, `PI_SLOW_BASE - 1)));  // normal region only
         d = $urandom;
         run_trans($sformatf("rnd_wr%0d", i), 1'b0, a, d, RDY, RDY);
         run_trans($sformatf("rnd_rd%0d", i), 1'b1, a, '0, RDY, WAT);
      end
      $display("%0d tests, %0d ok, %0d failed, %0d errors", n_pass + n_fail, n_pass,
               n_fail, errors);
      if (errors == 0)
         $display("*** PASSED ***");
      else
         $display("*** FAILED ***");
      $finish;
   end

   // cycle budget from the number of transactions
   initial
   begin
      cycles = 0;
      wait (cycle_limit > 0);
      while (cycles < cycle_limit)
      begin
         @(posedge clk);
         cycles++;
      end
      $display("run stopped after %0d cycles, the bus stopped answering", cycle_limit);
      $display("*** FAILED ***");
      $finish;
   end

endmodule

// File: sources.f
+incdir+rtl
rtl/pi_bus_pkg.sv
rtl/pi_slave_if.sv
rtl/pi_addr_decoder.sv
rtl/pi_slave_fsm.sv
rtl/pi_slave_store.sv
rtl/pi_resp_collector.sv
rtl/pi_bus_top.sv
sim/pi_bus_sva.sv
sim/pi_bus_tb.sv
